// File: hdl/vic_pkg.sv
package vic_pkg;

   // ==================================================
   // Widths with a meaning
   // ==================================================
   typedef logic [15:0] addr_t;      // CPU address, 64 KB space
   typedef logic [7:0]  byte_t;
   typedef logic [31:0] ldr_addr_t;  // Loader address, page in top byte
   typedef logic [7:0]  page_t;
   typedef logic [3:0]  nib_t;       // Colour fields
   typedef logic [6:0]  xorg_t;      // X origin, columns, rows

   // Memory owner
   typedef enum logic [1:0] {
      ARB_CPU,    // CPU drives memory
      ARB_DRAIN,  // Halt seen, finishing CPU access
      ARB_LDR     // Loader drives memory
   } arb_state_t;

   // ==================================================
   // Clocking and memory
   // ==================================================
   localparam int CLKDIV_MOD = 25;                  // 25 MHz down to 1 MHz
   localparam int CLKDIV_W   = $clog2(CLKDIV_MOD);
   localparam int MEM_DEPTH  = 1 << $bits(addr_t);

   // Loader map
   localparam page_t LDR_PAGE_CTRL  = 8'hFF;
   localparam page_t LDR_PAGE_RAM   = 8'h00;
   localparam int    CTRL_RESET_BIT = 0;
   localparam int    CTRL_HALT_BIT  = 1;

   // Video chip register block, 9000..900F
   localparam logic [11:0] VIC_REG_PAGE = 12'h900;

   // Write protected top nibbles, kernal/basic/char ROM
   localparam int ROM_NIB_NUM = 5;
   localparam logic [ROM_NIB_NUM-1:0][3:0] ROM_NIBBLES = {4'hF, 4'hE, 4'hD, 4'hC, 4'h8};

   // Video power-on values
   localparam addr_t SCREEN_DEF    = 16'h1E00;
   localparam addr_t CHAR_ROM_DEF  = 16'h8000;
   localparam addr_t COLOR_RAM_DEF = 16'h9400;
   localparam xorg_t XORIGIN_DEF   = 7'd12;
   localparam byte_t YORIGIN_DEF   = 8'd38;
   localparam xorg_t COLS_DEF      = 7'd22;
   localparam xorg_t ROWS_DEF      = 7'd23;

endpackage

// File: hdl/vic_mem_if.sv
`timescale 1ns/1ps

// One memory request channel
interface vic_mem_if;

   logic           req;    // One cycle per access
   logic           we;
   vic_pkg::addr_t addr;
   vic_pkg::byte_t wdata;
   vic_pkg::byte_t rdata;  // Cycle after req, held until next req

   modport requester (
      output req, we, addr, wdata,
      input  rdata
   );

   modport arbiter (
      input  req, we, addr, wdata,
      output rdata
   );

   // Snooping only
   modport monitor (
      input req, we, addr, wdata, rdata
   );

endinterface

// File: hdl/cpu_bus_port.sv
`timescale 1ns/1ps

module cpu_bus_port (
   input  logic            clk25,
   input  logic            pwr_up_reset_n,
   input  logic            i_psel,
   input  logic            i_penable,
   input  logic            i_pwrite,
   input  vic_pkg::addr_t  i_paddr,
   input  vic_pkg::byte_t  i_pwdata,
   output vic_pkg::byte_t  o_prdata,
   output logic            o_pready,
   input  logic            i_halt,
   vic_mem_if.requester    mem
);

   logic [vic_pkg::CLKDIV_W-1:0] div_cnt;
   logic cpu_clken;   // 1 MHz strobe
   logic acc_go;      // Access phase lines up with enable
   logic rom_hit;
   logic pready_r;

   // ==================================================
   // CPU clock enable
   // ==================================================
   always_ff @(posedge clk25) begin
      if (!pwr_up_reset_n) begin
         div_cnt   <= '0;
         cpu_clken <= 1'b0;
      end else begin
         if (div_cnt == (vic_pkg::CLKDIV_MOD - 1)) begin
            div_cnt <= '0;                  // Wrap at 24
         end else begin
            div_cnt <= div_cnt + 1'b1;
         end
         cpu_clken <= (div_cnt == 0) & ~i_halt;  // Frozen while halted
      end
   end

   // ROM page check on the top nibble
   always_comb begin
      rom_hit = 1'b0;
      for (int k = 0; k < vic_pkg::ROM_NIB_NUM; k++) begin
         if (i_paddr[15:12] == vic_pkg::ROM_NIBBLES[k]) begin
            rom_hit = 1'b1;
         end
      end
   end

   // ==================================================
   // Access sequencer
   // ==================================================
   // Wait in access phase for the enable, then one request
   assign acc_go = i_psel & i_penable & cpu_clken & ~pready_r;

   assign mem.req   = acc_go & ~(i_pwrite & rom_hit);  // ROM writes dropped here
   assign mem.we    = i_pwrite;
   assign mem.addr  = i_paddr;
   assign mem.wdata = i_pwdata;

   // Completion one cycle after the request slot
   always_ff @(posedge clk25) begin
      if (!pwr_up_reset_n) begin
         pready_r <= 1'b0;
      end else begin
         pready_r <= acc_go;
      end
   end

   assign o_pready = pready_r;
   assign o_prdata = mem.rdata;  // Valid with pready on reads

endmodule

// File: hdl/loader_port.sv
`timescale 1ns/1ps

module loader_port (
   input  logic               clk25,
   input  logic               pwr_up_reset_n,
   input  logic               i_ldr_wr,
   input  logic               i_ldr_rd,
   input  vic_pkg::ldr_addr_t i_ldr_addr,
   input  vic_pkg::byte_t     i_ldr_wdata,
   output vic_pkg::byte_t     o_ldr_rdata,
   output logic               o_ldr_valid,
   input  logic               i_ldr_grant,
   output logic               o_halt,
   output logic               o_cpu_reset,
   vic_mem_if.requester       mem
);

   vic_pkg::page_t                 page;
   logic [vic_pkg::CTRL_HALT_BIT:0] ctrl_r;   // Bit 0 reset, bit 1 halt
   logic                           ram_hit;
   logic                           rd_pend;

   assign page    = i_ldr_addr[31:24];
   assign ram_hit = (page == vic_pkg::LDR_PAGE_RAM);

   // ==================================================
   // Control register at page FF
   // ==================================================
   always_ff @(posedge clk25) begin
      if (!pwr_up_reset_n) begin
         ctrl_r <= '0;
      end else if (i_ldr_wr && page == vic_pkg::LDR_PAGE_CTRL) begin
         ctrl_r <= i_ldr_wdata[vic_pkg::CTRL_HALT_BIT:0];
      end
   end

   assign o_halt      = ctrl_r[vic_pkg::CTRL_HALT_BIT];
   assign o_cpu_reset = ctrl_r[vic_pkg::CTRL_RESET_BIT];

   // Page 00 memory path dropped unless granted
   assign mem.req   = (i_ldr_wr | i_ldr_rd) & ram_hit & i_ldr_grant;
   assign mem.we    = i_ldr_wr;
   assign mem.addr  = i_ldr_addr[15:0];
   assign mem.wdata = i_ldr_wdata;

   // Read data flag one cycle behind the request
   always_ff @(posedge clk25) begin
      if (!pwr_up_reset_n) begin
         rd_pend <= 1'b0;
      end else begin
         rd_pend <= i_ldr_rd & ram_hit & i_ldr_grant;
      end
   end

   assign o_ldr_valid = rd_pend;
   assign o_ldr_rdata = mem.rdata;

endmodule

// File: hdl/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter (
   input  logic           clk25,
   input  logic           pwr_up_reset_n,
   input  logic           i_halt,
   output logic           o_ldr_grant,
   vic_mem_if.arbiter     cpu_ch,
   vic_mem_if.arbiter     ldr_ch,
   output logic           o_ram_we,
   output vic_pkg::addr_t o_ram_addr,
   output vic_pkg::byte_t o_ram_wdata,
   input  vic_pkg::byte_t i_ram_rdata
);

   vic_pkg::arb_state_t state;
   vic_pkg::arb_state_t state_nxt;
   logic                ldr_sel;
   logic                cpu_rd_d;   // CPU request last cycle
   logic                ldr_rd_d;
   vic_pkg::byte_t      cpu_hold;   // Last CPU read byte
   vic_pkg::byte_t      ldr_hold;

   // ==================================================
   // Ownership FSM
   // ==================================================
   always_comb begin
      state_nxt = state;
      case (state)
         vic_pkg::ARB_CPU: begin
            if (i_halt) begin
               state_nxt = vic_pkg::ARB_DRAIN;
            end
         end
         vic_pkg::ARB_DRAIN: begin
            if (!i_halt) begin
               state_nxt = vic_pkg::ARB_CPU;   // Halt withdrawn
            end else if (!cpu_ch.req) begin
               state_nxt = vic_pkg::ARB_LDR;   // Nothing left in flight
            end
         end
         vic_pkg::ARB_LDR: begin
            if (!i_halt) begin
               state_nxt = vic_pkg::ARB_CPU;
            end
         end
         default: state_nxt = vic_pkg::ARB_CPU;
      endcase
   end

   always_ff @(posedge clk25) begin
      if (!pwr_up_reset_n) begin
         state <= vic_pkg::ARB_CPU;
      end else begin
         state <= state_nxt;
      end
   end

   // Grant drops with halt, state follows a cycle later
   assign ldr_sel     = (state == vic_pkg::ARB_LDR) & i_halt;
   assign o_ldr_grant = ldr_sel;

   // Owner onto the RAM port
   assign o_ram_we    = ldr_sel ? (ldr_ch.req & ldr_ch.we) : (cpu_ch.req & cpu_ch.we);
   assign o_ram_addr  = ldr_sel ? ldr_ch.addr  : cpu_ch.addr;
   assign o_ram_wdata = ldr_sel ? ldr_ch.wdata : cpu_ch.wdata;

   // ==================================================
   // Read return
   // ==================================================
   always_ff @(posedge clk25) begin
      if (!pwr_up_reset_n) begin
         cpu_rd_d <= 1'b0;
         ldr_rd_d <= 1'b0;
      end else begin
         cpu_rd_d <= cpu_ch.req & ~ldr_sel;
         ldr_rd_d <= ldr_ch.req & ldr_sel;
      end
   end

   always_ff @(posedge clk25) begin
      if (cpu_rd_d) begin
         cpu_hold <= i_ram_rdata;
      end
      if (ldr_rd_d) begin
         ldr_hold <= i_ram_rdata;
      end
   end

   // Fresh byte straight from RAM, then held
   assign cpu_ch.rdata = cpu_rd_d ? i_ram_rdata : cpu_hold;
   assign ldr_ch.rdata = ldr_rd_d ? i_ram_rdata : ldr_hold;

endmodule

// File: hdl/vic_ram.sv
`timescale 1ns/1ps

module vic_ram (
   input  logic           clk25,
   input  logic           i_we,
   input  vic_pkg::addr_t i_addr,
   input  vic_pkg::byte_t i_wdata,
   output vic_pkg::byte_t o_rdata
);

   // 64K x 8, cleared at power-on
   vic_pkg::byte_t mem_array [vic_pkg::MEM_DEPTH] = '{default: 8'h00};

   always_ff @(posedge clk25) begin
      if (i_we) begin
         mem_array[i_addr] <= i_wdata;
      end
      o_rdata <= mem_array[i_addr];  // Registered read, old data on write
   end

endmodule

// File: hdl/vic_regs.sv
`timescale 1ns/1ps

module vic_regs (
   input  logic           clk25,
   input  logic           pwr_up_reset_n,
   vic_mem_if.monitor     cpu_ch,
   output vic_pkg::addr_t o_screen_addr,
   output vic_pkg::addr_t o_char_rom_addr,
   output vic_pkg::addr_t o_color_ram_addr,
   output vic_pkg::xorg_t o_xorigin,
   output vic_pkg::xorg_t o_cols,
   output vic_pkg::xorg_t o_rows,
   output vic_pkg::byte_t o_yorigin,
   output logic [2:0]     o_border_color,
   output vic_pkg::nib_t  o_back_color,
   output vic_pkg::nib_t  o_aux_color,
   output logic           o_inverted,
   output logic           o_chars8x16
);

   logic           reg_wr;  // CPU write into 9000..900F
   vic_pkg::byte_t d;

   assign reg_wr = cpu_ch.req & cpu_ch.we & (cpu_ch.addr[15:4] == vic_pkg::VIC_REG_PAGE);
   assign d      = cpu_ch.wdata;

   always_ff @(posedge clk25) begin
      if (!pwr_up_reset_n) begin
         o_screen_addr    <= vic_pkg::SCREEN_DEF;
         o_char_rom_addr  <= vic_pkg::CHAR_ROM_DEF;
         o_color_ram_addr <= vic_pkg::COLOR_RAM_DEF;
         o_xorigin        <= vic_pkg::XORIGIN_DEF;
         o_yorigin        <= vic_pkg::YORIGIN_DEF;
         o_cols           <= vic_pkg::COLS_DEF;
         o_rows           <= vic_pkg::ROWS_DEF;
         o_border_color   <= '0;
         o_back_color     <= '0;
         o_aux_color      <= '0;
         o_inverted       <= 1'b0;
         o_chars8x16      <= 1'b0;
      end else if (reg_wr) begin
         case (cpu_ch.addr[3:0])
            4'h0: o_xorigin <= d[6:0];
            4'h1: o_yorigin <= d;
            4'h2: begin                      // Columns, address bit 9
               o_screen_addr[9]    <= d[7];
               o_color_ram_addr[9] <= d[7];
               o_cols              <= d[6:0];
            end
            4'h3: begin
               o_chars8x16 <= d[0];           // Tall characters
               o_rows      <= d[6:0];
            end
            4'h5: begin
               // Low nibble char ROM, high nibble screen
               o_char_rom_addr[15]    <= ~d[3];
               o_char_rom_addr[12:10] <= d[2:0];
               o_screen_addr[15]      <= ~d[7];
               o_screen_addr[12:10]   <= d[6:4];
            end
            4'hE: o_aux_color <= d[7:4];
            4'hF: begin
               o_border_color <= d[2:0];
               o_inverted     <= d[3];
               o_back_color   <= d[7:4];
            end
            default: ;                         // Sound and raster offsets ignored
         endcase
      end
   end

endmodule

// File: hdl/vic_core_top.sv
`timescale 1ns/1ps

module vic_core_top (
   input  logic               clk25,
   input  logic               pwr_up_reset_n,
   // APB slave, CPU side
   input  logic               i_psel,
   input  logic               i_penable,
   input  logic               i_pwrite,
   input  vic_pkg::addr_t     i_paddr,
   input  vic_pkg::byte_t     i_pwdata,
   output vic_pkg::byte_t     o_prdata,
   output logic               o_pready,
   // Loader, in place of the SPI slave
   input  logic               i_ldr_wr,
   input  logic               i_ldr_rd,
   input  vic_pkg::ldr_addr_t i_ldr_addr,
   input  vic_pkg::byte_t     i_ldr_wdata,
   output vic_pkg::byte_t     o_ldr_rdata,
   output logic               o_ldr_valid,
   output logic               o_halt,
   output logic               o_cpu_reset,
   // Video configuration
   output vic_pkg::addr_t     o_screen_addr,
   output vic_pkg::addr_t     o_char_rom_addr,
   output vic_pkg::addr_t     o_color_ram_addr,
   output vic_pkg::xorg_t     o_xorigin,
   output vic_pkg::xorg_t     o_cols,
   output vic_pkg::xorg_t     o_rows,
   output vic_pkg::byte_t     o_yorigin,
   output logic [2:0]         o_border_color,
   output vic_pkg::nib_t      o_back_color,
   output vic_pkg::nib_t      o_aux_color,
   output logic               o_inverted,
   output logic               o_chars8x16
);

   logic           halt;
   logic           ldr_grant;
   logic           ram_we;
   vic_pkg::addr_t ram_addr;
   vic_pkg::byte_t ram_wdata;
   vic_pkg::byte_t ram_rdata;

   // ==================================================
   // Request channels
   // ==================================================
   vic_mem_if cpu_ch ();
   vic_mem_if ldr_ch ();

   assign o_halt = halt;

   cpu_bus_port cpu_port0 (
      .clk25          (clk25),
      .pwr_up_reset_n (pwr_up_reset_n),
      .i_psel         (i_psel),
      .i_penable      (i_penable),
      .i_pwrite       (i_pwrite),
      .i_paddr        (i_paddr),
      .i_pwdata       (i_pwdata),
      .o_prdata       (o_prdata),
      .o_pready       (o_pready),
      .i_halt         (halt),
      .mem            (cpu_ch.requester)
   );

   loader_port ldr_port0 (
      .clk25          (clk25),
      .pwr_up_reset_n (pwr_up_reset_n),
      .i_ldr_wr       (i_ldr_wr),
      .i_ldr_rd       (i_ldr_rd),
      .i_ldr_addr     (i_ldr_addr),
      .i_ldr_wdata    (i_ldr_wdata),
      .o_ldr_rdata    (o_ldr_rdata),
      .o_ldr_valid    (o_ldr_valid),
      .i_ldr_grant    (ldr_grant),
      .o_halt         (halt),
      .o_cpu_reset    (o_cpu_reset),
      .mem            (ldr_ch.requester)
   );

   mem_arbiter arb0 (
      .clk25          (clk25),
      .pwr_up_reset_n (pwr_up_reset_n),
      .i_halt         (halt),
      .o_ldr_grant    (ldr_grant),
      .cpu_ch         (cpu_ch.arbiter),
      .ldr_ch         (ldr_ch.arbiter),
      .o_ram_we       (ram_we),
      .o_ram_addr     (ram_addr),
      .o_ram_wdata    (ram_wdata),
      .i_ram_rdata    (ram_rdata)
   );

   vic_ram ram0 (
      .clk25   (clk25),
      .i_we    (ram_we),
      .i_addr  (ram_addr),
      .i_wdata (ram_wdata),
      .o_rdata (ram_rdata)
   );

   // Snoops CPU writes only
   vic_regs regs0 (
      .clk25            (clk25),
      .pwr_up_reset_n   (pwr_up_reset_n),
      .cpu_ch           (cpu_ch.monitor),
      .o_screen_addr    (o_screen_addr),
      .o_char_rom_addr  (o_char_rom_addr),
      .o_color_ram_addr (o_color_ram_addr),
      .o_xorigin        (o_xorigin),
      .o_cols           (o_cols),
      .o_rows           (o_rows),
      .o_yorigin        (o_yorigin),
      .o_border_color   (o_border_color),
      .o_back_color     (o_back_color),
      .o_aux_color      (o_aux_color),
      .o_inverted       (o_inverted),
      .o_chars8x16      (o_chars8x16)
   );

endmodule

// File: tb/vic_asserts.sv
`timescale 1ns/1ps

module vic_asserts (
   input logic clk25,
   input logic pwr_up_reset_n,
   input logic i_halt,
   input logic i_ldr_grant,
   input logic i_cpu_req,
   input logic i_ldr_req,
   input logic i_ldr_we
);

   int assert_fails = 0;   // Failed assertion count

   // ==================================================
   // Memory ownership
   // ==================================================
   a_single_req: assert property (@(posedge clk25) disable iff (!pwr_up_reset_n)
      !(i_cpu_req && i_ldr_req))
      else begin
         assert_fails++;
         $error("CPU and loader requests reached memory in the same cycle");
      end

   // Grant only with no CPU access pending
   a_grant_idle: assert property (@(posedge clk25) disable iff (!pwr_up_reset_n)
      i_ldr_grant |-> !i_cpu_req)
      else begin
         assert_fails++;
         $error("Loader grant high while a CPU access is pending");
      end

   a_ldr_wr_halt: assert property (@(posedge clk25) disable iff (!pwr_up_reset_n)
      (i_ldr_req && i_ldr_we) |-> i_halt)
      else begin
         assert_fails++;
         $error("Loader memory write without halt");
      end

endmodule

bind mem_arbiter vic_asserts arb_chk0 (
   .clk25          (clk25),
   .pwr_up_reset_n (pwr_up_reset_n),
   .i_halt         (i_halt),
   .i_ldr_grant    (o_ldr_grant),
   .i_cpu_req      (cpu_ch.req),
   .i_ldr_req      (ldr_ch.req),
   .i_ldr_we       (ldr_ch.we)
);

// File: tb/tb_vic.sv
`timescale 1ns/1ps

module tb_vic;

   logic               clk25 = 1'b0;
   logic               pwr_up_reset_n;
   logic               i_psel;
   logic               i_penable;
   logic               i_pwrite;
   vic_pkg::addr_t     i_paddr;
   vic_pkg::byte_t     i_pwdata;
   vic_pkg::byte_t     o_prdata;
   logic               o_pready;
   logic               i_ldr_wr;
   logic               i_ldr_rd;
   vic_pkg::ldr_addr_t i_ldr_addr;
   vic_pkg::byte_t     i_ldr_wdata;
   vic_pkg::byte_t     o_ldr_rdata;
   logic               o_ldr_valid;
   logic               o_halt;
   logic               o_cpu_reset;
   vic_pkg::addr_t     o_screen_addr;
   vic_pkg::addr_t     o_char_rom_addr;
   vic_pkg::addr_t     o_color_ram_addr;
   vic_pkg::xorg_t     o_xorigin;
   vic_pkg::xorg_t     o_cols;
   vic_pkg::xorg_t     o_rows;
   vic_pkg::byte_t     o_yorigin;
   logic [2:0]         o_border_color;
   vic_pkg::nib_t      o_back_color;
   vic_pkg::nib_t      o_aux_color;
   logic               o_inverted;
   logic               o_chars8x16;

   int mism_errs  = 0;
   int other_errs = 0;
   int n_lines    = 0;   // Stimulus lines, sizes the watchdog

   // Parsed stimulus columns
   string              op_q[$];
   string              name_q[$];
   vic_pkg::ldr_addr_t addr_q[$];
   vic_pkg::byte_t     data_q[$];
   logic [15:0]        exp_q[$];

   always #2 clk25 = ~clk25;   // 4 ns period

   vic_core_top dut0 (.*);

   // ==================================================
   // Compare tasks
   // ==================================================
   task automatic check_byte(input string nm, input vic_pkg::byte_t ex, input vic_pkg::byte_t act);
      if (act !== ex) begin
         mism_errs++;
         $display("Mismatch %s: expected %02h, actual %02h", nm, ex, act);
      end
   endtask

   task automatic check_addr(input string nm, input vic_pkg::addr_t ex, input vic_pkg::addr_t act);
      if (act !== ex) begin
         mism_errs++;
         $display("Mismatch %s: expected %04h, actual %04h", nm, ex, act);
      end
   endtask

   task automatic check_field(input string nm, input vic_pkg::xorg_t ex, input vic_pkg::xorg_t act);
      if (act !== ex) begin
         mism_errs++;
         $display("Mismatch %s: expected %02h, actual %02h", nm, ex, act);
      end
   endtask

   task automatic check_nib(input string nm, input vic_pkg::nib_t ex, input vic_pkg::nib_t act);
      if (act !== ex) begin
         mism_errs++;
         $display("Mismatch %s: expected %01h, actual %01h", nm, ex, act);
      end
   endtask

   task automatic check_bit(input string nm, input logic ex, input logic act);
      if (act !== ex) begin
         mism_errs++;
         $display("Mismatch %s: expected %b, actual %b", nm, ex, act);
      end
   endtask

   task automatic report_counts();
      $display("Errors: %0d mismatch, %0d protocol, %0d assertion",
               mism_errs, other_errs, dut0.arb0.arb_chk0.assert_fails);
   endtask

   // ==================================================
   // Bus drivers, all on the falling edge
   // ==================================================
   task automatic apb_start(input logic wr, input vic_pkg::addr_t addr, input vic_pkg::byte_t wd);
      @(negedge clk25);
      i_psel    = 1'b1;   // Setup phase
      i_penable = 1'b0;
      i_pwrite  = wr;
      i_paddr   = addr;
      i_pwdata  = wd;
      @(negedge clk25);
      i_penable = 1'b1;   // Access phase
   endtask

   task automatic apb_finish(output vic_pkg::byte_t rd);
      do begin
         @(negedge clk25);
      end while (!o_pready);
      rd = o_prdata;
      @(negedge clk25);        // Transfer done on the edge just passed
      i_psel    = 1'b0;
      i_penable = 1'b0;
   endtask

   task automatic apb_access(input logic wr, input vic_pkg::addr_t addr,
                             input vic_pkg::byte_t wd, output vic_pkg::byte_t rd);
      apb_start(wr, addr, wd);
      apb_finish(rd);
   endtask

   // Single cycle loader strobe
   task automatic ldr_strobe(input logic wr, input vic_pkg::ldr_addr_t addr, input vic_pkg::byte_t wd);
      @(negedge clk25);
      i_ldr_addr  = addr;
      i_ldr_wdata = wd;
      i_ldr_wr    = wr;
      i_ldr_rd    = ~wr;
      @(negedge clk25);
      i_ldr_wr = 1'b0;
      i_ldr_rd = 1'b0;
   endtask

   task automatic ldr_gap();
      repeat (4) @(negedge clk25);   // Strobe spacing
   endtask

   task automatic ldr_read(input string nm, input vic_pkg::ldr_addr_t addr, input vic_pkg::byte_t ex);
      int k;
      ldr_strobe(1'b0, addr, 8'h00);
      k = 0;
      while (!o_ldr_valid && k < 4) begin
         @(negedge clk25);
         k++;
      end
      if (o_ldr_valid) begin
         check_byte(nm, ex, o_ldr_rdata);
      end else begin
         other_errs++;
         $display("%s: loader read at %08h never raised valid", nm, addr);
      end
      ldr_gap();
   endtask

   // APB write started under halt, released by a control write
   task automatic held_write(input string nm, input vic_pkg::addr_t addr,
                             input vic_pkg::byte_t wd, input vic_pkg::byte_t ctrl);
      vic_pkg::byte_t rd;
      apb_start(1'b1, addr, wd);
      repeat (32) begin
         @(negedge clk25);
         if (o_pready) begin
            other_errs++;
            $display("%s: CPU access completed while the CPU was halted", nm);
         end
      end
      ldr_strobe(1'b1, {vic_pkg::LDR_PAGE_CTRL, 24'h000000}, ctrl);
      apb_finish(rd);
      ldr_gap();
   endtask

   task automatic video_check(input string nm, input logic [3:0] fld, input logic [15:0] ex);
      @(negedge clk25);
      case (fld)
         4'h0: check_addr(nm, ex, o_screen_addr);
         4'h1: check_addr(nm, ex, o_char_rom_addr);
         4'h2: check_addr(nm, ex, o_color_ram_addr);
         4'h3: check_field(nm, ex[6:0], o_xorigin);
         4'h4: check_field(nm, ex[6:0], o_cols);
         4'h5: check_field(nm, ex[6:0], o_rows);
         4'h6: check_byte(nm, ex[7:0], o_yorigin);
         4'h7: check_nib(nm, ex[3:0], {1'b0, o_border_color});
         4'h8: check_nib(nm, ex[3:0], o_back_color);
         4'h9: check_nib(nm, ex[3:0], o_aux_color);
         4'hA: check_bit(nm, ex[0], o_inverted);
         4'hB: check_bit(nm, ex[0], o_chars8x16);
         4'hC: check_bit(nm, ex[0], o_cpu_reset);
         4'hD: check_bit(nm, ex[0], o_halt);
         default: begin
            other_errs++;
            $display("%s: unknown video field code %h", nm, fld);
         end
      endcase
   endtask

   // ==================================================
   // Stimulus file
   // ==================================================
   task automatic load_stim();
      int                 fd;
      string              line;
      string              op;
      string              nm;
      vic_pkg::ldr_addr_t addr;
      vic_pkg::byte_t     wd;
      logic [15:0]        ex;
      fd = $fopen("tb/vic_stim.txt", "r");
      if (fd == 0) begin
         other_errs++;
         $display("Could not open the stimulus file tb/vic_stim.txt");
         return;
      end
      while ($fgets(line, fd) != 0) begin
         if (line.len() > 1 && line.getc(0) != "#") begin   // Skip notes and blanks
            if ($sscanf(line, "%s %h %h %h %s", op, addr, wd, ex, nm) == 5) begin
               op_q.push_back(op);
               addr_q.push_back(addr);
               data_q.push_back(wd);
               exp_q.push_back(ex);
               name_q.push_back(nm);
            end else begin
               other_errs++;
               $display("Malformed stimulus line: %s", line);
            end
         end
      end
      $fclose(fd);
      n_lines = op_q.size();
   endtask

   task automatic run_line(input int idx);
      vic_pkg::byte_t rd;
      string          nm;
      logic [15:0]    ex;
      nm = name_q[idx];
      ex = exp_q[idx];
      case (op_q[idx])
         "CW": apb_access(1'b1, addr_q[idx][15:0], data_q[idx], rd);
         "CR": begin
            apb_access(1'b0, addr_q[idx][15:0], 8'h00, rd);
            check_byte(nm, ex[7:0], rd);
         end
         "CH": held_write(nm, addr_q[idx][15:0], data_q[idx], ex[7:0]);
         "LW": begin
            ldr_strobe(1'b1, addr_q[idx], data_q[idx]);
            ldr_gap();
         end
         "LR": ldr_read(nm, addr_q[idx], ex[7:0]);
         "VC": video_check(nm, addr_q[idx][3:0], ex);
         default: begin
            other_errs++;
            $display("%s: unknown operation %s", nm, op_q[idx]);
         end
      endcase
   endtask

   // ==================================================
   // Main sequence and verdict
   // ==================================================
   initial begin
      pwr_up_reset_n = 1'b0;
      i_psel         = 1'b0;
      i_penable      = 1'b0;
      i_pwrite       = 1'b0;
      i_paddr        = '0;
      i_pwdata       = '0;
      i_ldr_wr       = 1'b0;
      i_ldr_rd       = 1'b0;
      i_ldr_addr     = '0;
      i_ldr_wdata    = '0;
      load_stim();
      repeat (10) @(negedge clk25);
      pwr_up_reset_n = 1'b1;
      repeat (2) @(negedge clk25);
      for (int i = 0; i < n_lines; i++) begin
         run_line(i);
      end
      repeat (4) @(negedge clk25);
      report_counts();
      if (mism_errs + other_errs + dut0.arb0.arb_chk0.assert_fails == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

   // Watchdog, 64 cycles per stimulus line plus reset
   initial begin
      wait (n_lines > 0);
      repeat ((n_lines + 1) * 64) @(posedge clk25);
      $display("Timeout: stimulus did not finish in %0d cycles", (n_lines + 1) * 64);
      report_counts();
      $display("TEST FAIL");
      $finish;
   end

endmodule

// File: tb/vic_stim.txt
# op addr data expect name; CW/CR cpu, CH cpu write held by halt, LW/LR loader, VC video check
# VC addr is a field code 0 screen 1 charrom 2 colram 3 xorg 4 cols 5 rows 6 yorg 7 border 8 back 9 aux A inv B 8x16 C reset D halt
VC 0 00 1E00 def_screen
VC 1 00 8000 def_char_rom
VC 2 00 9400 def_color_ram
VC 3 00 000C def_xorigin
VC 4 00 0016 def_cols
VC 5 00 0017 def_rows
VC 6 00 0026 def_yorigin
VC C 00 0000 def_cpu_reset
CW 1000 5A 0000 ram_wr_a
CW 2345 C3 0000 ram_wr_b
CR 1000 00 005A ram_rd_a
CR 2345 00 00C3 ram_rd_b
LW FF000000 02 0000 halt_on
VC D 00 0001 halt_set
LW 00008010 A5 0000 rom_load_8
LW 0000E123 3C 0000 rom_load_e
LR 00008010 00 00A5 rom_rdback_8
LR 0000E123 00 003C rom_rdback_e
LR 00001000 00 005A ldr_rd_ram
CH 2345 77 0000 held_wr
VC D 00 0000 halt_clear
LW 00002345 EE 0000 ldr_wr_no_halt
CR 2345 00 0077 held_rdback
CW 8010 FF 0000 rom_wr_8
CW E123 00 0000 rom_wr_e
CR 8010 00 00A5 rom_rd_8
CR E123 00 003C rom_rd_e
CW 9002 99 0000 vic_wr_cols
CW 9003 2F 0000 vic_wr_rows
CW 9005 2C 0000 vic_wr_base
CW 900E 50 0000 vic_wr_aux
CW 900F 6B 0000 vic_wr_color
VC 0 00 8A00 vic_screen
VC 1 00 1000 vic_char_rom
VC 2 00 9600 vic_color_ram
VC 3 00 000C vic_xorigin
VC 4 00 0019 vic_cols
VC 5 00 002F vic_rows
VC B 00 0001 vic_8x16
VC 7 00 0003 vic_border
VC 8 00 0006 vic_back
VC 9 00 0005 vic_aux
VC A 00 0001 vic_inverted
LW FF000000 01 0000 reset_on
VC C 00 0001 cpu_reset_high
LW FF000000 00 0000 reset_off
VC C 00 0000 cpu_reset_low

// File: vlog.f
hdl/vic_pkg.sv
hdl/vic_mem_if.sv
hdl/cpu_bus_port.sv
hdl/loader_port.sv
hdl/mem_arbiter.sv
hdl/vic_ram.sv
hdl/vic_regs.sv
hdl/vic_core_top.sv
tb/vic_asserts.sv
tb/tb_vic.sv

// File: Bender.yml
package:
  name: vic_core

sources:
  - files:
      - hdl/vic_pkg.sv
      - hdl/vic_mem_if.sv
      - hdl/cpu_bus_port.sv
      - hdl/loader_port.sv
      - hdl/mem_arbiter.sv
      - hdl/vic_ram.sv
      - hdl/vic_regs.sv
      - hdl/vic_core_top.sv
  - target: test
    files:
      - tb/vic_asserts.sv
      - tb/tb_vic.sv
